// File: common/core_pkg.sv
// core_pkg: shared widths, types and RV32I encodings for the pipeline
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // first fetch address
    localparam word_t RESET_PC = 32'h0000_0000;

    // --------------------------------------------------
    // major opcodes kept by this core
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // funct7 of SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

`default_nettype wire

// File: fetch/fetch_unit.sv
// fetch_unit: program counter and one-deep instruction request/response handshake
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire logic  i_exec,
    input  wire logic  i_imem_req_ready,
    input  wire logic  i_imem_rsp_valid,
    input  wire word_t i_imem_rsp_data,
    input  wire logic  i_redirect_valid,
    input  wire word_t i_redirect_pc,
    output logic       o_imem_req_valid,
    output word_t      o_imem_addr,
    output logic       o_fetch_valid,
    output word_t      o_fetch_inst,
    output word_t      o_fetch_pc
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQ,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e state_q;
    // address of the pending or next request
    word_t        pc_q;
    // address of the request in flight, also the debug pc
    word_t        req_pc_q;
    word_t        tgt_q;
    logic         drop_q;
    logic         rsp_beat;

    assign rsp_beat         = (state_q == FETCH_WAIT) && i_imem_rsp_valid;
    assign o_imem_req_valid = (state_q == FETCH_REQ);
    assign o_imem_addr      = pc_q;

    // response goes straight into the decode register
    assign o_fetch_valid = rsp_beat && !drop_q;
    assign o_fetch_inst  = i_imem_rsp_data;
    assign o_fetch_pc    = req_pc_q;

    // --------------------------------------------------
    // request FSM
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q  <= FETCH_IDLE;
            pc_q     <= RESET_PC;
            req_pc_q <= RESET_PC;
            drop_q   <= 1'b0;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    if (i_exec) begin
                        state_q <= FETCH_REQ;
                    end
                end
                FETCH_REQ: begin
                    // address holds until the memory takes it
                    if (i_imem_req_ready) begin
                        state_q  <= FETCH_WAIT;
                        req_pc_q <= pc_q;
                    end
                end
                FETCH_WAIT: begin
                    if (i_imem_rsp_valid) begin
                        state_q <= FETCH_REQ;
                        if (i_redirect_valid) begin
                            pc_q <= i_redirect_pc;
                        end else if (drop_q) begin
                            pc_q <= tgt_q;
                        end else begin
                            pc_q <= req_pc_q + 32'd4;
                        end
                    end
                end
                default: begin
                    state_q <= FETCH_IDLE;
                end
            endcase

            // stale response after a redirect
            if (rsp_beat) begin
                drop_q <= 1'b0;
            end else if (i_redirect_valid) begin
                drop_q <= 1'b1;
            end
        end
    end

    // redirect target, used once the stale response is gone
    always_ff @(posedge i_clk) begin
        if (i_redirect_valid) begin
            tgt_q <= i_redirect_pc;
        end
    end

    a_req_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_imem_req_valid && !i_imem_req_ready |=> o_imem_req_valid && $stable(o_imem_addr));

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
// decode stage that splits fields, builds the immediate and alu op, and registers them
`timescale 1ns/100ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire logic  i_fetch_valid,
    input  wire word_t i_fetch_inst,
    input  wire word_t i_fetch_pc,
    input  wire word_t i_rs1_data,
    input  wire word_t i_rs2_data,
    input  wire logic  i_redirect_valid,
    output reg_addr_t  o_rs1_addr,
    output reg_addr_t  o_rs2_addr,
    output logic       o_dec_valid,
    output word_t      o_dec_pc,
    output word_t      o_dec_imm,
    output word_t      o_dec_rs1_val,
    output word_t      o_dec_rs2_val,
    output reg_addr_t  o_dec_rs1,
    output reg_addr_t  o_dec_rs2,
    output reg_addr_t  o_dec_rd,
    output alu_op_e    o_dec_alu_op,
    output logic       o_dec_use_imm,
    output logic       o_dec_wr_en,
    output logic       o_dec_branch,
    output logic       o_dec_branch_ne,
    output logic       o_dec_jal
);

    opcode_e    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm;
    alu_op_e    alu_op;
    alu_op_e    f3_op;
    logic       f3_ok;
    logic       use_imm;
    logic       wr_en;
    logic       branch;
    logic       branch_ne;
    logic       jal;

    assign opc        = opcode_e'(i_fetch_inst[6:0]);
    assign rd         = i_fetch_inst[11:7];
    assign funct3     = i_fetch_inst[14:12];
    assign funct7     = i_fetch_inst[31:25];
    assign o_rs1_addr = i_fetch_inst[19:15];
    assign o_rs2_addr = i_fetch_inst[24:20];

    // funct3 to alu op for register and immediate forms
    always_comb begin
        f3_op = ALU_ADD;
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD_SUB: f3_op = (opc == OPC_OP && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            F3_XOR:     f3_op = ALU_XOR;
            F3_OR:      f3_op = ALU_OR;
            F3_AND:     f3_op = ALU_AND;
            default:    f3_ok = 1'b0;
        endcase
    end

    always_comb begin
        alu_op    = f3_op;
        imm       = {{20{i_fetch_inst[31]}}, i_fetch_inst[31:20]};
        use_imm   = 1'b0;
        wr_en     = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        jal       = 1'b0;
        case (opc)
            OPC_OP: begin
                // other funct7 values are not RV32I and run as no-ops
                wr_en = f3_ok && (funct7 == '0 || (funct3 == F3_ADD_SUB && funct7 == F7_SUB));
            end
            OPC_OP_IMM: begin
                wr_en   = f3_ok;
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                imm     = {i_fetch_inst[31:12], 12'h000};
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
                wr_en   = 1'b1;
            end
            OPC_BRANCH: begin
                imm       = {{19{i_fetch_inst[31]}}, i_fetch_inst[31], i_fetch_inst[7],
                             i_fetch_inst[30:25], i_fetch_inst[11:8], 1'b0};
                branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branch_ne = (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                imm   = {{11{i_fetch_inst[31]}}, i_fetch_inst[31], i_fetch_inst[19:12],
                         i_fetch_inst[20], i_fetch_inst[30:21], 1'b0};
                wr_en = 1'b1;
                jal   = 1'b1;
            end
            // anything else runs as a no-op
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

    // --------------------------------------------------
    // decode register
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_dec_valid <= 1'b0;
        end else begin
            o_dec_valid <= i_fetch_valid && !i_redirect_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_dec_pc        <= i_fetch_pc;
        o_dec_imm       <= imm;
        o_dec_rs1_val   <= i_rs1_data;
        o_dec_rs2_val   <= i_rs2_data;
        o_dec_rs1       <= o_rs1_addr;
        o_dec_rs2       <= o_rs2_addr;
        o_dec_rd        <= rd;
        o_dec_alu_op    <= alu_op;
        o_dec_use_imm   <= use_imm;
        // x0 is never a write target
        o_dec_wr_en     <= wr_en && (rd != '0);
        o_dec_branch    <= branch;
        o_dec_branch_ne <= branch_ne;
        o_dec_jal       <= jal;
    end

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
// execute_stage: forwarding, alu, branch and jump resolution, writeback register
`timescale 1ns/100ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_dec_valid,
    input  wire word_t     i_dec_pc,
    input  wire word_t     i_dec_imm,
    input  wire word_t     i_dec_rs1_val,
    input  wire word_t     i_dec_rs2_val,
    input  wire reg_addr_t i_dec_rs1,
    input  wire reg_addr_t i_dec_rs2,
    input  wire reg_addr_t i_dec_rd,
    input  wire alu_op_e   i_dec_alu_op,
    input  wire logic      i_dec_use_imm,
    input  wire logic      i_dec_wr_en,
    input  wire logic      i_dec_branch,
    input  wire logic      i_dec_branch_ne,
    input  wire logic      i_dec_jal,
    output logic           o_wb_valid,
    output reg_addr_t      o_wb_rd,
    output word_t          o_wb_data,
    output logic           o_redirect_valid,
    output word_t          o_redirect_pc
);

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_res;
    word_t rd_val;
    logic  src_eq;
    logic  taken;

    // --------------------------------------------------
    // operands, previous result wins over a stale read
    // --------------------------------------------------
    assign op_a  = (o_wb_valid && o_wb_rd == i_dec_rs1) ? o_wb_data : i_dec_rs1_val;
    assign op_b  = (o_wb_valid && o_wb_rd == i_dec_rs2) ? o_wb_data : i_dec_rs2_val;
    assign alu_b = i_dec_use_imm ? i_dec_imm : op_b;

    always_comb begin
        case (i_dec_alu_op)
            ALU_ADD:    alu_res = op_a + alu_b;
            ALU_SUB:    alu_res = op_a - alu_b;
            ALU_AND:    alu_res = op_a & alu_b;
            ALU_OR:     alu_res = op_a | alu_b;
            ALU_XOR:    alu_res = op_a ^ alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = alu_b;
        endcase
    end

    // link value for jal
    assign rd_val = i_dec_jal ? i_dec_pc + 32'd4 : alu_res;

    // beq and bne share the compare
    assign src_eq = (op_a == op_b);
    assign taken  = i_dec_valid && (i_dec_jal || (i_dec_branch && (src_eq != i_dec_branch_ne)));

    // --------------------------------------------------
    // writeback and redirect registers
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb_valid       <= 1'b0;
            o_redirect_valid <= 1'b0;
        end else begin
            o_wb_valid       <= i_dec_valid && i_dec_wr_en;
            o_redirect_valid <= taken;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd       <= i_dec_rd;
        o_wb_data     <= rd_val;
        o_redirect_pc <= i_dec_pc + i_dec_imm;
    end

    // fetch spacing keeps wrong-path work out of the cycle after a redirect
    a_redirect_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_redirect_valid |=> !o_redirect_valid);

endmodule

`default_nettype wire

// File: design/reg_file.sv
// reg_file: 32 x 32 register file with write bypass and a debug read port
`timescale 1ns/100ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_wr_en,
    input  wire reg_addr_t i_wr_addr,
    input  wire word_t     i_wr_data,
    input  wire reg_addr_t i_rd_addr1,
    input  wire reg_addr_t i_rd_addr2,
    input  wire reg_addr_t i_dbg_addr,
    output word_t          o_rd_data1,
    output word_t          o_rd_data2,
    output word_t          o_dbg_data
);

    word_t regs_q [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs_q[i_wr_addr] <= i_wr_data;
        end
    end

    // x0 reads zero, the register being written reads its new value
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wr_en && addr == i_wr_addr) begin
            return i_wr_data;
        end
        return regs_q[addr];
    endfunction

    always_comb begin
        o_rd_data1 = read_port(i_rd_addr1);
        o_rd_data2 = read_port(i_rd_addr2);
        o_dbg_data = read_port(i_dbg_addr);
    end

    // decode drops rd of zero before it gets here
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr_en |-> i_wr_addr != '0);

endmodule

`default_nettype wire

// File: design/core.sv
// core: RV32I integer pipeline top level with fetch, decode, execute and registers
`timescale 1ns/100ps
`default_nettype none

module core import core_pkg::*; (
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_exec,

    // instruction request and response
    output logic           o_imem_req_valid,
    output word_t          o_imem_addr,
    input  wire logic      i_imem_req_ready,
    input  wire logic      i_imem_rsp_valid,
    input  wire word_t     i_imem_rsp_data,

    // debug
    input  wire reg_addr_t i_dbg_addr,
    output word_t          o_dbg_data,
    output word_t          o_pc
);

    // fetch to decode
    logic      fetch_valid;
    word_t     fetch_inst;
    word_t     fetch_pc;

    // register read
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // decode to execute
    logic      dec_valid;
    word_t     dec_pc;
    word_t     dec_imm;
    word_t     dec_rs1_val;
    word_t     dec_rs2_val;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    alu_op_e   dec_alu_op;
    logic      dec_use_imm;
    logic      dec_wr_en;
    logic      dec_branch;
    logic      dec_branch_ne;
    logic      dec_jal;

    // writeback and redirect
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      redirect_valid;
    word_t     redirect_pc;

    // pc of the last accepted request
    assign o_pc = fetch_pc;

    fetch_unit u_fetch (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_exec           (i_exec),
        .i_imem_req_ready (i_imem_req_ready),
        .i_imem_rsp_valid (i_imem_rsp_valid),
        .i_imem_rsp_data  (i_imem_rsp_data),
        .i_redirect_valid (redirect_valid),
        .i_redirect_pc    (redirect_pc),
        .o_imem_req_valid (o_imem_req_valid),
        .o_imem_addr      (o_imem_addr),
        .o_fetch_valid    (fetch_valid),
        .o_fetch_inst     (fetch_inst),
        .o_fetch_pc       (fetch_pc)
    );

    decode_stage u_decode (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_fetch_valid    (fetch_valid),
        .i_fetch_inst     (fetch_inst),
        .i_fetch_pc       (fetch_pc),
        .i_rs1_data       (rs1_data),
        .i_rs2_data       (rs2_data),
        .i_redirect_valid (redirect_valid),
        .o_rs1_addr       (rs1_addr),
        .o_rs2_addr       (rs2_addr),
        .o_dec_valid      (dec_valid),
        .o_dec_pc         (dec_pc),
        .o_dec_imm        (dec_imm),
        .o_dec_rs1_val    (dec_rs1_val),
        .o_dec_rs2_val    (dec_rs2_val),
        .o_dec_rs1        (dec_rs1),
        .o_dec_rs2        (dec_rs2),
        .o_dec_rd         (dec_rd),
        .o_dec_alu_op     (dec_alu_op),
        .o_dec_use_imm    (dec_use_imm),
        .o_dec_wr_en      (dec_wr_en),
        .o_dec_branch     (dec_branch),
        .o_dec_branch_ne  (dec_branch_ne),
        .o_dec_jal        (dec_jal)
    );

    execute_stage u_execute (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_dec_valid      (dec_valid),
        .i_dec_pc         (dec_pc),
        .i_dec_imm        (dec_imm),
        .i_dec_rs1_val    (dec_rs1_val),
        .i_dec_rs2_val    (dec_rs2_val),
        .i_dec_rs1        (dec_rs1),
        .i_dec_rs2        (dec_rs2),
        .i_dec_rd         (dec_rd),
        .i_dec_alu_op     (dec_alu_op),
        .i_dec_use_imm    (dec_use_imm),
        .i_dec_wr_en      (dec_wr_en),
        .i_dec_branch     (dec_branch),
        .i_dec_branch_ne  (dec_branch_ne),
        .i_dec_jal        (dec_jal),
        .o_wb_valid       (wb_valid),
        .o_wb_rd          (wb_rd),
        .o_wb_data        (wb_data),
        .o_redirect_valid (redirect_valid),
        .o_redirect_pc    (redirect_pc)
    );

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_en    (wb_valid),
        .i_wr_addr  (wb_rd),
        .i_wr_data  (wb_data),
        .i_rd_addr1 (rs1_addr),
        .i_rd_addr2 (rs2_addr),
        .i_dbg_addr (i_dbg_addr),
        .o_rd_data1 (rs1_data),
        .o_rd_data2 (rs2_data),
        .o_dbg_data (o_dbg_data)
    );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
// tb_clock: free-running clock source for the testbench
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_core.sv
// testbench for the pipeline core with a randomized instruction memory and register checks
`timescale 1ns/100ps
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam real CLK_PERIOD       = 4.0;
    localparam int  RESET_CYCLES     = 10;
    localparam int  MEM_WORDS        = 64;
    localparam int  PROG_LEN         = 22;
    localparam int  LOOP_PASSES      = 3;
    // worst single fetch with ready stalls and a 4-cycle response
    localparam int  FETCH_CYCLES_MAX = 20;
    localparam int  WATCHDOG_CYCLES  =
        (RESET_CYCLES + (PROG_LEN + 2 * LOOP_PASSES + 4) * FETCH_CYCLES_MAX) * 5;

    // control transfers taken by the program
    localparam word_t BEQ_PC     = 32'h0000_0030;
    localparam word_t BEQ_TARGET = 32'h0000_003C;
    localparam word_t JAL_PC     = 32'h0000_0044;
    localparam word_t JAL_TARGET = 32'h0000_0050;
    localparam word_t LOOP_PC    = 32'h0000_0054;

    logic        clk;
    logic        rst_n;
    logic        exec;
    logic        imem_req_valid;
    word_t       imem_addr;
    logic        imem_req_ready;
    logic        imem_rsp_valid;
    word_t       imem_rsp_data;
    reg_addr_t   dbg_addr;
    word_t       dbg_data;
    word_t       pc;

    word_t       mem [MEM_WORDS];
    word_t       expected_regs [32];
    logic [15:0] lfsr_q;
    logic        started;
    int          accepted;
    int          loop_passes;
    word_t       last_addr;
    word_t       addr_before_last;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.o_clk(clk));

    core UUT (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_exec           (exec),
        .o_imem_req_valid (imem_req_valid),
        .o_imem_addr      (imem_addr),
        .i_imem_req_ready (imem_req_ready),
        .i_imem_rsp_valid (imem_rsp_valid),
        .i_imem_rsp_data  (imem_rsp_data),
        .i_dbg_addr       (dbg_addr),
        .o_dbg_data       (dbg_data),
        .o_pc             (pc)
    );

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic fail_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string test_name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("Error: %s expected 0x%08h actual 0x%08h", test_name, expected, actual);
            fail_run();
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic random_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t lui_word(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t branch_word(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jal_word(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            // custom-0 opcode runs as a no-op here
            mem[i] = {i[24:0], 7'b0001011};
        end
        mem[0]  = i_type(12'h123, 5'd0, 3'b000, 5'd1);            // addi x1, x0, 0x123
        mem[1]  = i_type(12'hFFA, 5'd0, 3'b000, 5'd2);            // addi x2, x0, -6
        mem[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);        // add  x3, x1, x2
        mem[3]  = r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);        // sub  x4, x3, x1
        mem[4]  = r_type(7'h00, 5'd3, 5'd4, 3'b100, 5'd5);        // xor  x5, x4, x3
        mem[5]  = lui_word(20'h12345, 5'd6);                      // lui  x6, 0x12345
        mem[6]  = r_type(7'h00, 5'd1, 5'd6, 3'b110, 5'd7);        // or   x7, x6, x1
        mem[7]  = r_type(7'h00, 5'd2, 5'd7, 3'b111, 5'd8);        // and  x8, x7, x2
        mem[8]  = i_type(12'h0F0, 5'd8, 3'b111, 5'd9);            // andi x9, x8, 0xf0
        mem[9]  = i_type(12'h70F, 5'd9, 3'b110, 5'd10);           // ori  x10, x9, 0x70f
        mem[10] = i_type(12'hFFF, 5'd10, 3'b100, 5'd11);          // xori x11, x10, -1
        mem[11] = i_type(12'h005, 5'd0, 3'b000, 5'd0);            // addi x0, x0, 5
        mem[12] = branch_word(13'd12, 5'd4, 5'd2, 3'b000);        // beq  x2, x4, +12
        mem[13] = i_type(12'h001, 5'd0, 3'b000, 5'd20);           // marker
        mem[14] = i_type(12'h001, 5'd0, 3'b000, 5'd21);           // marker
        mem[15] = branch_word(13'd8, 5'd1, 5'd1, 3'b001);         // bne  x1, x1, +8
        mem[16] = i_type(12'h055, 5'd0, 3'b000, 5'd12);           // addi x12, x0, 0x55
        mem[17] = jal_word(21'd12, 5'd13);                        // jal  x13, +12
        mem[18] = i_type(12'h001, 5'd0, 3'b000, 5'd22);           // marker
        mem[19] = i_type(12'h001, 5'd0, 3'b000, 5'd23);           // marker
        mem[20] = r_type(7'h00, 5'd13, 5'd12, 3'b000, 5'd14);     // add  x14, x12, x13
        mem[21] = jal_word(21'd0, 5'd0);                          // jal  x0, 0
    endtask

    // final register values worked out by hand
    task automatic build_expected_table();
        for (int r = 0; r < 32; r++) begin
            expected_regs[r] = 32'h0000_0000;
        end
        expected_regs[1]  = 32'h0000_0123;
        expected_regs[2]  = 32'hFFFF_FFFA;
        expected_regs[3]  = 32'h0000_011D;
        expected_regs[4]  = 32'hFFFF_FFFA;
        expected_regs[5]  = 32'hFFFF_FEE7;
        expected_regs[6]  = 32'h1234_5000;
        expected_regs[7]  = 32'h1234_5123;
        expected_regs[8]  = 32'h1234_5122;
        expected_regs[9]  = 32'h0000_0020;
        expected_regs[10] = 32'h0000_072F;
        expected_regs[11] = 32'hFFFF_F8D0;
        expected_regs[12] = 32'h0000_0055;
        expected_regs[13] = 32'h0000_0048;
        expected_regs[14] = 32'h0000_009D;
    endtask

    // next address is +4 or the target two accepts after a taken transfer
    task automatic check_fetch_order(input word_t addr);
        word_t expected;
        expected = last_addr + 32'd4;
        if (accepted == 0) begin
            expected = RESET_PC;
        end else if (accepted >= 2 && addr_before_last == BEQ_PC) begin
            expected = BEQ_TARGET;
        end else if (accepted >= 2 && addr_before_last == JAL_PC) begin
            expected = JAL_TARGET;
        end else if (accepted >= 2 && addr_before_last == LOOP_PC) begin
            expected = LOOP_PC;
        end
        check_word("fetch address", expected, addr);
        addr_before_last = last_addr;
        last_addr        = addr;
        accepted++;
        if (addr == LOOP_PC) begin
            loop_passes++;
        end
    endtask

    // --------------------------------------------------
    // request channel properties
    // --------------------------------------------------
    a_idle_until_exec: assert property (@(posedge clk) started && !exec |-> !imem_req_valid)
    else begin
        $display("instruction request raised before the start input");
        fail_run();
    end

    a_request_holds: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_addr))
    else begin
        $display("request dropped or address changed under back-pressure");
        fail_run();
    end

    // --------------------------------------------------
    // instruction memory model
    // --------------------------------------------------
    initial begin : memory_model
        logic  fire;
        logic  pending;
        word_t fire_addr;
        word_t rsp_addr;
        int    countdown;
        pending   = 1'b0;
        countdown = 0;
        rsp_addr  = '0;
        @(posedge rst_n);
        forever begin
            // sample mid cycle where all values are settled
            @(negedge clk);
            fire      = imem_req_valid && imem_req_ready;
            fire_addr = imem_addr;
            check_word("debug pc", (accepted > 0) ? last_addr : RESET_PC, pc);
            @(posedge clk);
            #0.5;
            imem_rsp_valid = 1'b0;
            if (fire) begin
                assert (!pending) else begin
                    $display("request accepted while another one is outstanding");
                    fail_run();
                end
                check_fetch_order(fire_addr);
                pending   = 1'b1;
                rsp_addr  = fire_addr;
                countdown = 1 + int'(random_bit());
                countdown = countdown + 2 * int'(random_bit());
            end
            if (pending) begin
                countdown = countdown - 1;
                if (countdown == 0) begin
                    pending        = 1'b0;
                    imem_rsp_valid = 1'b1;
                    imem_rsp_data  = mem[rsp_addr[7:2]];
                end
            end
            imem_req_ready = random_bit();
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired, self-loop not reached within %0d cycles", WATCHDOG_CYCLES);
        fail_run();
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main_sequence
        rst_n            = 1'b0;
        exec             = 1'b0;
        imem_req_ready   = 1'b0;
        imem_rsp_valid   = 1'b0;
        imem_rsp_data    = '0;
        dbg_addr         = '0;
        lfsr_q           = 16'd23868;
        started          = 1'b0;
        accepted         = 0;
        loop_passes      = 0;
        last_addr        = RESET_PC;
        addr_before_last = RESET_PC;
        load_program();
        build_expected_table();

        @(posedge clk);
        #0.5;
        started = 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        // idle a few cycles before the start
        repeat (3) @(posedge clk);
        #0.5;
        exec = 1'b1;

        while (loop_passes < LOOP_PASSES) begin
            @(posedge clk);
        end

        // every register through the debug port including x0 and the markers
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #0.5;
            dbg_addr = reg_addr_t'(r);
            @(negedge clk);
            check_word($sformatf("register x%0d", r), expected_regs[r], dbg_data);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
common/core_pkg.sv
fetch/fetch_unit.sv
decode/decode_stage.sv
execute/execute_stage.sv
design/reg_file.sv
design/core.sv
verif/tb_clock.sv
verif/tb_core.sv

// File: Makefile
# Verilator lint, build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TEST RESULT: PASS
VFLAGS    ?= --timing --assert

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides pass or fail, not the exit status of the run
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
